/* hdl/oq_buffer_pkg.sv */
`default_nettype none

package oq_buffer_pkg;

    ////////////////////////////////////////////////////////////
    // packet storage sizes
    ////////////////////////////////////////////////////////////

    // one beat is one buffer word
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // one word always stays on the free list
    localparam int BUF_DEPTH = 32;
    localparam int BUF_ADDR_W = 5;

    localparam int MAX_PKT_WORDS = 8;

    // almost full once a maximum size packet no longer fits
    localparam int ALMOST_FULL_FREE = MAX_PKT_WORDS;

    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [DATA_W-1:0]     pkt_data_t;
    typedef logic [KEEP_W-1:0]     pkt_keep_t;

    // usable free words, 0 to 31
    typedef logic [BUF_ADDR_W-1:0] free_count_t;

endpackage

`default_nettype wire

/* hdl/oq_sched_pkg.sv */
`default_nettype none

package oq_sched_pkg;

    ////////////////////////////////////////////////////////////
    // scheduling types
    ////////////////////////////////////////////////////////////

    localparam int RANK_W = 16;
    localparam int PIFO_DEPTH = 8;

    // lower rank is served earlier
    typedef logic [RANK_W-1:0] rank_t;

    // occupied entries, 0 to PIFO_DEPTH
    typedef logic [3:0] pifo_count_t;

    // dequeue FSM
    typedef enum logic
    {
        DEQ_IDLE = 1'b0,
        DEQ_READ = 1'b1
    } deq_state_t;

endpackage

`default_nettype wire

/* hdl/pkt_link_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_link_buffer
(
    input  wire logic                      axis_aclk,
    input  wire logic                      axis_resetn,
    input  wire logic                      s_axis_tvalid,
    input  wire oq_buffer_pkg::pkt_data_t  s_axis_tdata,
    input  wire oq_buffer_pkg::pkt_keep_t  s_axis_tkeep,
    input  wire logic                      s_axis_tlast,
    input  wire logic                      rd_en,
    input  wire oq_buffer_pkg::buf_addr_t  rd_addr,
    output logic                           pkt_commit,
    output oq_buffer_pkg::buf_addr_t       commit_addr,
    output oq_buffer_pkg::pkt_data_t       rd_data,
    output oq_buffer_pkg::pkt_keep_t       rd_keep,
    output logic                           rd_last,
    output oq_buffer_pkg::buf_addr_t       rd_next_addr,
    output logic                           buffer_almost_full
);
    import oq_buffer_pkg::*;

    // word storage
    pkt_data_t   data_mem [BUF_DEPTH];
    pkt_keep_t   keep_mem [BUF_DEPTH];
    logic        last_mem [BUF_DEPTH];

    // shared link table for packets and the free list
    buf_addr_t   next_ptr [BUF_DEPTH];

    buf_addr_t   fl_head;
    buf_addr_t   fl_tail;
    buf_addr_t   head_next;
    buf_addr_t   pkt_start;
    free_count_t free_cnt;
    logic        wr_en;

    assign wr_en     = s_axis_tvalid;
    assign head_next = next_ptr[fl_head];

    ////////////////////////////////////////////////////////////
    // write and read ports
    ////////////////////////////////////////////////////////////

    // beats land on the free-list head, so consecutive beats follow the free chain
    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            data_mem[fl_head] <= s_axis_tdata;
            keep_mem[fl_head] <= s_axis_tkeep;
            last_mem[fl_head] <= s_axis_tlast;
        end
    end

    // read register only loads on rd_en and holds otherwise
    always_ff @(posedge axis_aclk)
    begin
        if (rd_en)
        begin
            rd_data      <= data_mem[rd_addr];
            rd_keep      <= keep_mem[rd_addr];
            rd_last      <= last_mem[rd_addr];
            rd_next_addr <= next_ptr[rd_addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // free list
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // whole buffer chained in address order
            for (int i = 0; i < BUF_DEPTH; i++)
            begin
                next_ptr[i] <= buf_addr_t'(i + 1);
            end
            fl_head   <= '0;
            fl_tail   <= buf_addr_t'(BUF_DEPTH - 1);
            pkt_start <= '0;
            free_cnt  <= free_count_t'(BUF_DEPTH - 1);
        end
        else
        begin
            if (wr_en)
            begin
                fl_head <= head_next;
            end
            // next packet starts where the head points after this last beat
            if (wr_en && s_axis_tlast)
            begin
                pkt_start <= head_next;
            end
            // freed word goes behind the tail
            if (rd_en)
            begin
                next_ptr[fl_tail] <= rd_addr;
                fl_tail           <= rd_addr;
            end
            case ({wr_en, rd_en})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    assign pkt_commit         = s_axis_tvalid & s_axis_tlast;
    assign commit_addr        = pkt_start;
    assign buffer_almost_full = (free_cnt < free_count_t'(ALMOST_FULL_FREE));

endmodule

`default_nettype wire

/* hdl/pifo_sorter.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_sorter
(
    input  wire logic                      axis_aclk,
    input  wire logic                      axis_resetn,
    input  wire logic                      insert_en,
    input  wire oq_sched_pkg::rank_t       insert_rank,
    input  wire oq_buffer_pkg::buf_addr_t  insert_addr,
    input  wire logic                      pop,
    output logic                           head_valid,
    output oq_buffer_pkg::buf_addr_t       head_addr,
    output logic                           pifo_full
);
    import oq_sched_pkg::*;
    import oq_buffer_pkg::*;

    // entries sorted by ascending rank, index 0 is the head
    rank_t                 rank_q [PIFO_DEPTH];
    buf_addr_t             addr_q [PIFO_DEPTH];
    pifo_count_t           count;

    // array after the pop shift, before the insert
    rank_t                 ext_rank [PIFO_DEPTH];
    buf_addr_t             ext_addr [PIFO_DEPTH];
    pifo_count_t           ext_count;
    logic [PIFO_DEPTH-1:0] ext_le;

    // array after the insert
    rank_t                 nxt_rank [PIFO_DEPTH];
    buf_addr_t             nxt_addr [PIFO_DEPTH];

    ////////////////////////////////////////////////////////////
    // insert position
    ////////////////////////////////////////////////////////////

    // a pop drops the old head before the new entry is placed
    always_comb
    begin
        ext_count = count - pifo_count_t'(pop);
        for (int i = 0; i < PIFO_DEPTH - 1; i++)
        begin
            ext_rank[i] = pop ? rank_q[i+1] : rank_q[i];
            ext_addr[i] = pop ? addr_q[i+1] : addr_q[i];
        end
        // past the kept entries after a pop
        ext_rank[PIFO_DEPTH-1] = rank_q[PIFO_DEPTH-1];
        ext_addr[PIFO_DEPTH-1] = addr_q[PIFO_DEPTH-1];
        // ext_le marks kept entries that stay ahead of the new one
        for (int i = 0; i < PIFO_DEPTH; i++)
        begin
            ext_le[i] = (pifo_count_t'(i) < ext_count) && (ext_rank[i] <= insert_rank);
        end
    end

    // entries behind the insert point move one slot down
    always_comb
    begin
        if (insert_en && !ext_le[0])
        begin
            nxt_rank[0] = insert_rank;
            nxt_addr[0] = insert_addr;
        end
        else
        begin
            nxt_rank[0] = ext_rank[0];
            nxt_addr[0] = ext_addr[0];
        end
        for (int i = 1; i < PIFO_DEPTH; i++)
        begin
            if (!insert_en || ext_le[i])
            begin
                nxt_rank[i] = ext_rank[i];
                nxt_addr[i] = ext_addr[i];
            end
            else if (ext_le[i-1])
            begin
                nxt_rank[i] = insert_rank;
                nxt_addr[i] = insert_addr;
            end
            else
            begin
                nxt_rank[i] = ext_rank[i-1];
                nxt_addr[i] = ext_addr[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        for (int i = 0; i < PIFO_DEPTH; i++)
        begin
            rank_q[i] <= nxt_rank[i];
            addr_q[i] <= nxt_addr[i];
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + pifo_count_t'(insert_en) - pifo_count_t'(pop);
        end
    end

    assign head_valid = (count != '0);
    assign head_addr  = addr_q[0];
    assign pifo_full  = (count == pifo_count_t'(PIFO_DEPTH));

endmodule

`default_nettype wire

/* hdl/dequeue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dequeue_ctrl
(
    input  wire logic                      axis_aclk,
    input  wire logic                      axis_resetn,
    input  wire logic                      head_valid,
    input  wire oq_buffer_pkg::buf_addr_t  head_addr,
    input  wire oq_buffer_pkg::pkt_data_t  rd_data,
    input  wire oq_buffer_pkg::pkt_keep_t  rd_keep,
    input  wire logic                      rd_last,
    input  wire oq_buffer_pkg::buf_addr_t  rd_next_addr,
    input  wire logic                      m_axis_tready,
    output logic                           pop,
    output logic                           rd_en,
    output oq_buffer_pkg::buf_addr_t       rd_addr,
    output logic                           m_axis_tvalid,
    output oq_buffer_pkg::pkt_data_t       m_axis_tdata,
    output oq_buffer_pkg::pkt_keep_t       m_axis_tkeep,
    output logic                           m_axis_tlast
);
    import oq_sched_pkg::*;

    deq_state_t state;
    deq_state_t state_next;
    logic       beat_accept;

    // a word is on the output for the whole of DEQ_READ
    assign m_axis_tvalid = (state == DEQ_READ);
    assign beat_accept   = m_axis_tvalid & m_axis_tready;

    ////////////////////////////////////////////////////////////
    // dequeue FSM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        pop        = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = rd_next_addr;
        case (state)
            DEQ_IDLE:
            begin
                // pop the head and fetch its first word in the same cycle
                if (head_valid)
                begin
                    pop        = 1'b1;
                    rd_en      = 1'b1;
                    rd_addr    = head_addr;
                    state_next = DEQ_READ;
                end
            end
            DEQ_READ:
            begin
                // follow the link only once the current word has left
                if (beat_accept)
                begin
                    if (rd_last)
                    begin
                        state_next = DEQ_IDLE;
                    end
                    else
                    begin
                        rd_en = 1'b1;
                    end
                end
            end
            default:
            begin
                state_next = DEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state <= DEQ_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // the buffer read register doubles as the output register, it holds while rd_en is low
    assign m_axis_tdata = rd_data;
    assign m_axis_tkeep = rd_keep;
    assign m_axis_tlast = rd_last;

endmodule

`default_nettype wire

/* hdl/output_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module output_queue
(
    input  wire logic                      axis_aclk,
    input  wire logic                      axis_resetn,
    input  wire logic                      s_axis_tvalid,
    input  wire oq_buffer_pkg::pkt_data_t  s_axis_tdata,
    input  wire oq_buffer_pkg::pkt_keep_t  s_axis_tkeep,
    input  wire logic                      s_axis_tlast,
    input  wire oq_sched_pkg::rank_t       s_axis_trank,
    output logic                           m_axis_tvalid,
    output oq_buffer_pkg::pkt_data_t       m_axis_tdata,
    output oq_buffer_pkg::pkt_keep_t       m_axis_tkeep,
    output logic                           m_axis_tlast,
    input  wire logic                      m_axis_tready,
    output logic                           buffer_almost_full,
    output logic                           pifo_full
);
    import oq_buffer_pkg::*;

    // enqueue side to scheduler
    logic      pkt_commit;
    buf_addr_t commit_addr;

    // scheduler to dequeue
    logic      head_valid;
    buf_addr_t head_addr;
    logic      pop;

    // dequeue reads from the buffer
    logic      rd_en;
    buf_addr_t rd_addr;
    pkt_data_t rd_data;
    pkt_keep_t rd_keep;
    logic      rd_last;
    buf_addr_t rd_next_addr;

    ////////////////////////////////////////////////////////////
    // storage and sorting side by side
    ////////////////////////////////////////////////////////////

    pkt_link_buffer u_buffer
    (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .s_axis_tvalid      (s_axis_tvalid),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tkeep       (s_axis_tkeep),
        .s_axis_tlast       (s_axis_tlast),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .pkt_commit         (pkt_commit),
        .commit_addr        (commit_addr),
        .rd_data            (rd_data),
        .rd_keep            (rd_keep),
        .rd_last            (rd_last),
        .rd_next_addr       (rd_next_addr),
        .buffer_almost_full (buffer_almost_full)
    );

    // rank is taken with the last beat
    pifo_sorter u_pifo
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .insert_en   (pkt_commit),
        .insert_rank (s_axis_trank),
        .insert_addr (commit_addr),
        .pop         (pop),
        .head_valid  (head_valid),
        .head_addr   (head_addr),
        .pifo_full   (pifo_full)
    );

    dequeue_ctrl u_deq
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .head_valid    (head_valid),
        .head_addr     (head_addr),
        .rd_data       (rd_data),
        .rd_keep       (rd_keep),
        .rd_last       (rd_last),
        .rd_next_addr  (rd_next_addr),
        .m_axis_tready (m_axis_tready),
        .pop           (pop),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

`default_nettype wire

/* tests/output_queue_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module output_queue_sva
(
    input wire logic                      axis_aclk,
    input wire logic                      axis_resetn,
    input wire logic                      m_axis_tvalid,
    input wire logic                      m_axis_tready,
    input wire oq_buffer_pkg::pkt_data_t  m_axis_tdata,
    input wire oq_buffer_pkg::pkt_keep_t  m_axis_tkeep,
    input wire logic                      m_axis_tlast
);

    ////////////////////////////////////////////////////////////
    // output stream rules
    ////////////////////////////////////////////////////////////

    // nothing leaves right after a reset cycle
    reset_quiet: assert property (@(posedge axis_aclk) !axis_resetn |=> !m_axis_tvalid)
        else $error("m_axis_tvalid high following a reset cycle");

    // stalled beat keeps its payload
    stall_stable: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (m_axis_tvalid && !m_axis_tready) |=>
        ($stable(m_axis_tdata) && $stable(m_axis_tkeep) && $stable(m_axis_tlast)))
        else $error("output payload changed while stalled");

    stall_valid: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid)
        else $error("m_axis_tvalid dropped before the beat was accepted");

endmodule

bind output_queue output_queue_sva u_sva
(
    .axis_aclk     (axis_aclk),
    .axis_resetn   (axis_resetn),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast)
);

`default_nettype wire

/* tests/tb_output_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_output_queue;
    import oq_buffer_pkg::*;
    import oq_sched_pkg::*;

    localparam int TIMEOUT = 4000;

    logic      axis_aclk;
    logic      axis_resetn;
    logic      s_axis_tvalid;
    pkt_data_t s_axis_tdata;
    pkt_keep_t s_axis_tkeep;
    logic      s_axis_tlast;
    rank_t     s_axis_trank;
    logic      m_axis_tvalid;
    pkt_data_t m_axis_tdata;
    pkt_keep_t m_axis_tkeep;
    logic      m_axis_tlast;
    logic      m_axis_tready;
    logic      buffer_almost_full;
    logic      pifo_full;

    // 0 low, 1 high, 2 random
    logic [1:0] ready_mode;

    // reference model, packets indexed by the tag in data[63:48]
    pkt_data_t beat_data [64][MAX_PKT_WORDS];
    pkt_keep_t beat_keep [64][MAX_PKT_WORDS];
    int        beat_len [64];
    int        pend_tag [$];
    rank_t     pend_rank [$];
    int        pend_cyc [$];
    int        out_tag [$];
    logic      out_active = 1'b0;
    int        exp_tag = 0;
    int        out_idx = 0;
    int        in_idx = 0;
    int        cyc = 0;
    int        last_commit_cyc = 0;
    int        next_tag = 0;
    int        words_out = 0;
    int        pkts_in = 0;
    int        pkts_out = 0;
    int        err_cnt = 0;
    logic      timed_out = 1'b0;
    string     test_name = "none";

    output_queue UUT (.*);

    always #5 axis_aclk = ~axis_aclk;

    always @(posedge axis_aclk)
    begin
        cyc <= cyc + 1;
        case (ready_mode)
            2'd0:    m_axis_tready <= 1'b0;
            2'd1:    m_axis_tready <= 1'b1;
            default: m_axis_tready <= 1'($urandom % 2);
        endcase
    end

    function automatic void report_mismatch(string what, logic [63:0] expected,
                                            logic [63:0] actual);
        err_cnt++;
        $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test_name, what, expected,
                 actual);
    endfunction

    function automatic void report_timeout(string what);
        err_cnt++;
        timed_out = 1'b1;
        $display("%s: timed out, %s", test_name, what);
    endfunction

    ////////////////////////////////////////////////////////////
    // monitors, sampled at the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge axis_aclk)
    begin
        int   best;
        logic exp_last;
        if (axis_resetn)
        begin
            // pop was one cycle earlier, so only packets committed before that qualify
            if (m_axis_tvalid && !out_active)
            begin
                best = -1;
                for (int i = 0; i < pend_tag.size(); i++)
                begin
                    if (pend_cyc[i] <= cyc - 2 && (best < 0 || pend_rank[i] < pend_rank[best]))
                        best = i;
                end
                if (best < 0)
                begin
                    err_cnt++;
                    $display("%s: output became valid with no packet waiting", test_name);
                end
                else
                begin
                    exp_tag = pend_tag[best];
                    pend_tag.delete(best);
                    pend_rank.delete(best);
                    pend_cyc.delete(best);
                    out_active = 1'b1;
                    out_idx = 0;
                end
            end
            if (m_axis_tvalid && m_axis_tready && out_active)
            begin
                if (out_idx == 0)
                    out_tag.push_back(int'(m_axis_tdata[63:48]));
                if (m_axis_tdata !== beat_data[exp_tag][out_idx])
                    report_mismatch("tdata", beat_data[exp_tag][out_idx], m_axis_tdata);
                if (m_axis_tkeep !== beat_keep[exp_tag][out_idx])
                    report_mismatch("tkeep", 64'(beat_keep[exp_tag][out_idx]), 64'(m_axis_tkeep));
                exp_last = (out_idx == beat_len[exp_tag] - 1);
                if (m_axis_tlast !== exp_last)
                    report_mismatch("tlast", 64'(exp_last), 64'(m_axis_tlast));
                out_idx++;
                words_out++;
                if (m_axis_tlast || exp_last)
                begin
                    out_active = 1'b0;
                    pkts_out++;
                end
            end
            // input side records each beat and the commit cycle of each packet
            if (s_axis_tvalid)
            begin
                beat_data[int'(s_axis_tdata[63:48])][in_idx] = s_axis_tdata;
                beat_keep[int'(s_axis_tdata[63:48])][in_idx] = s_axis_tkeep;
                in_idx++;
                if (s_axis_tlast)
                begin
                    beat_len[int'(s_axis_tdata[63:48])] = in_idx;
                    in_idx = 0;
                    pend_tag.push_back(int'(s_axis_tdata[63:48]));
                    pend_rank.push_back(s_axis_trank);
                    pend_cyc.push_back(cyc);
                    last_commit_cyc = cyc;
                    pkts_in++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic send_packet(input int nbeats, input rank_t rank, input logic gaps);
        int wait_cnt;
        wait_cnt = 0;
        // a packet starts only while both full levels are low
        @(negedge axis_aclk);
        while ((buffer_almost_full || pifo_full) && wait_cnt < TIMEOUT)
        begin
            @(negedge axis_aclk);
            wait_cnt++;
        end
        if (wait_cnt >= TIMEOUT)
        begin
            report_timeout("full levels stayed high");
            return;
        end
        for (int i = 0; i < nbeats; i++)
        begin
            @(posedge axis_aclk);
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= {16'(next_tag), 8'(i), 8'($urandom), 32'($urandom)};
            s_axis_tkeep  <= pkt_keep_t'($urandom);
            s_axis_tlast  <= (i == nbeats - 1);
            s_axis_trank  <= rank;
            if (gaps && ($urandom % 3 == 0))
            begin
                @(posedge axis_aclk);
                s_axis_tvalid <= 1'b0;
            end
        end
        @(posedge axis_aclk);
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
        next_tag++;
    endtask

    task automatic wait_drain();
        int wait_cnt;
        wait_cnt = 0;
        while ((pend_tag.size() != 0 || out_active) && wait_cnt < TIMEOUT)
        begin
            @(posedge axis_aclk);
            wait_cnt++;
        end
        if (wait_cnt >= TIMEOUT)
            report_timeout("queued packets did not drain");
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_levels();
        test_name = "reset_levels";
        @(negedge axis_aclk);
        if (m_axis_tvalid !== 1'b0)
            report_mismatch("m_axis_tvalid", 64'd0, 64'(m_axis_tvalid));
        if (buffer_almost_full !== 1'b0)
            report_mismatch("buffer_almost_full", 64'd0, 64'(buffer_almost_full));
        if (pifo_full !== 1'b0)
            report_mismatch("pifo_full", 64'd0, 64'(pifo_full));
    endtask

    task automatic test_single_packet();
        int wait_cnt;
        test_name = "single_packet";
        ready_mode <= 2'd1;
        send_packet(3, rank_t'(5), 1'b0);
        wait_cnt = 0;
        @(negedge axis_aclk);
        while (!m_axis_tvalid && wait_cnt < TIMEOUT)
        begin
            @(negedge axis_aclk);
            wait_cnt++;
        end
        if (wait_cnt >= TIMEOUT)
        begin
            report_timeout("no output beat appeared");
            return;
        end
        if (cyc - last_commit_cyc != 2)
            report_mismatch("first beat latency", 64'd2, 64'(cyc - last_commit_cyc));
        wait_drain();
    endtask

    task automatic test_rank_order();
        int base;
        int exp_order [5];
        test_name = "rank_order";
        // rank 9 arrives alone and is popped at once, the others sort behind it
        exp_order = '{0, 4, 1, 3, 2};
        base = next_tag;
        out_tag.delete();
        ready_mode <= 2'd0;
        send_packet(2, rank_t'(9), 1'b0);
        send_packet(3, rank_t'(3), 1'b0);
        send_packet(1, rank_t'(7), 1'b0);
        send_packet(2, rank_t'(3), 1'b0);
        send_packet(4, rank_t'(1), 1'b0);
        ready_mode <= 2'd1;
        wait_drain();
        if (out_tag.size() != 5)
        begin
            report_mismatch("packet count", 64'd5, 64'(out_tag.size()));
            return;
        end
        for (int i = 0; i < 5; i++)
        begin
            if (out_tag[i] != base + exp_order[i])
                report_mismatch("packet tag", 64'(base + exp_order[i]), 64'(out_tag[i]));
        end
    endtask

    task automatic test_random_traffic();
        int base_words;
        test_name = "random_traffic";
        base_words = words_out;
        ready_mode <= 2'd2;
        for (int i = 0; i < 40 && !timed_out; i++)
            send_packet(1 + int'($urandom % MAX_PKT_WORDS), rank_t'($urandom % 8), 1'b1);
        wait_drain();
        // enough words to wrap the free list several times
        if (words_out - base_words < 3 * BUF_DEPTH)
        begin
            err_cnt++;
            $display("%s: only %0d words came out, buffer not reused", test_name,
                     words_out - base_words);
        end
    endtask

    task automatic test_full_levels();
        test_name = "full_levels";
        ready_mode <= 2'd0;
        // first packet sits in the output register, eight more fill the PIFO
        for (int i = 0; i < 9 && !timed_out; i++)
            send_packet(3, rank_t'(i), 1'b0);
        @(negedge axis_aclk);
        if (pifo_full !== 1'b1)
            report_mismatch("pifo_full", 64'd1, 64'(pifo_full));
        if (buffer_almost_full !== 1'b1)
            report_mismatch("buffer_almost_full", 64'd1, 64'(buffer_almost_full));
        ready_mode <= 2'd1;
        wait_drain();
        @(negedge axis_aclk);
        if (pifo_full !== 1'b0)
            report_mismatch("pifo_full after drain", 64'd0, 64'(pifo_full));
        if (buffer_almost_full !== 1'b0)
            report_mismatch("buffer_almost_full after drain", 64'd0, 64'(buffer_almost_full));
    endtask

    initial
    begin
        void'($urandom(39));
        axis_aclk     = 1'b0;
        axis_resetn   = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_trank  = '0;
        m_axis_tready = 1'b0;
        ready_mode    = 2'd0;
        repeat (8) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
        test_reset_levels();
        if (!timed_out)
            test_single_packet();
        if (!timed_out)
            test_rank_order();
        if (!timed_out)
            test_random_traffic();
        if (!timed_out)
            test_full_levels();
        $display("packets in %0d, packets out %0d, errors %0d", pkts_in, pkts_out, err_cnt);
        if (err_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* output_queue.f */
hdl/oq_buffer_pkg.sv
hdl/oq_sched_pkg.sv
hdl/pkt_link_buffer.sv
hdl/pifo_sorter.sv
hdl/dequeue_ctrl.sv
hdl/output_queue.sv
tests/output_queue_sva.sv
tests/tb_output_queue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the output queue testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_output_queue --Mdir "$BUILD_DIR" \
    -f output_queue.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_output_queue" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG_FILE"; then
    exit 0
fi
exit 1
